// File: files.f
hdl/n64_host_pkg.sv
hdl/pifrom_loader.sv
hdl/cart_loader.sv
hdl/backup_ctrl.sv
hdl/config_decode.sv
hdl/n64_host_bridge.sv
test/tb_clock.sv
test/n64_host_checker.sv
test/tb_n64_host_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the host bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_n64_host_bridge -f files.f -o sim_host_bridge

sim_status=0
./obj_dir/sim_host_bridge > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "TEST PASSED" sim.log; then
	echo "Simulation ended abnormally"
	exit 1
fi

// File: test/tb_n64_host_bridge.sv
// Host bridge testbench
// Boot-ROM and cartridge downloads, backup triggers, image tracking
// and configuration decode against reference models
`timescale 1ns/1ps

module tb_n64_host_bridge import n64_host_pkg::*; ();

	localparam int PIF_PAIRS   = 32;
	localparam int CART_PAIRS  = 40;
	localparam int CFG_VECTORS = 20;
	// About four times the worst case of all tests together
	localparam int TIMEOUT_CYCLES = 4000;

	logic         clk_1x;
	logic         arst_n;
	ioctl_bus_t   ioctl;
	logic         ioctl_wait;
	logic         pif_wr;
	pif_wr_t      pif_req;
	logic         ram_wr;
	ram_req_t     ram_req;
	logic         ram_ready;
	logic         cart_loaded;
	host_status_t status;
	logic         osd_status;
	logic [1:0]   buttons;
	logic         img_mounted;
	logic         img_readonly;
	logic [31:0]  img_size;
	logic         bk_load;
	logic         bk_save;
	logic         use_img;
	sys_cfg_t     sys_cfg;
	logic         core_reset;

	integer   seed = 56;
	pif_wr_t  pif_q[$];
	ram_req_t ram_q[$];
	int       pif_cnt;
	int       ram_cnt;
	int       cycle_cnt = 0;

	tb_clock u_clock (.clk_1x(clk_1x), .arst_n(arst_n));

	n64_host_bridge dut0 (.*);

	// ====================
	// Reporting and checks
	// ====================
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	task automatic check_pif(input pif_wr_t exp, input pif_wr_t got);
		if (got !== exp)
			report_failure($sformatf("Mismatch at %0t: pif_req expected %h got %h",
				$time, exp, got));
	endtask

	task automatic check_ram(input ram_req_t exp, input ram_req_t got);
		if (got !== exp)
			report_failure($sformatf("Mismatch at %0t: ram_req expected %h got %h",
				$time, exp, got));
	endtask

	task automatic check_cfg(input sys_cfg_t exp, input sys_cfg_t got);
		if (got !== exp)
			report_failure($sformatf("Mismatch at %0t: sys_cfg expected %h got %h",
				$time, exp, got));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp)
			report_failure($sformatf("Mismatch at %0t: %s expected %b got %b",
				$time, name, exp, got));
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (got != exp)
			report_failure($sformatf("Mismatch at %0t: %s expected %0d got %0d",
				$time, name, exp, got));
	endtask

	// ====================
	// Reference models
	// ====================
	// Each word byte swapped, first word in the upper half
	function automatic pif_wr_t swap_pif_pair(input ioctl_index_t idx, input ioctl_addr_t addr,
		input ioctl_word_t w0, input ioctl_word_t w1);
		pif_wr_t p;
		p.addr = {idx[6], addr[10:2]};
		p.data = {w0[7:0], w0[15:8], w1[7:0], w1[15:8]};
		return p;
	endfunction

	function automatic ram_req_t pack_cart_pair(input ioctl_addr_t addr,
		input ioctl_word_t w0, input ioctl_word_t w1);
		ram_req_t r;
		r.addr = addr + CART_BASE_ADDR;
		r.data = {w1, w0};
		return r;
	endfunction

	function automatic sys_cfg_t decode_status(input host_status_t st);
		sys_cfg_t   c;
		logic [2:0] save_bits;
		save_bits     = st[ST_SAVETYPE_LO +: 3];
		c.pal         = st[ST_PAL];
		c.ram8mb      = !st[ST_RAM4MB];
		c.cic_type    = st[ST_CIC_LO +: 4];
		c.save_type   = save_type_t'(save_bits);
		c.eeprom_type = (save_bits == 3'd1) ? EEP_4K : (save_bits == 3'd2) ? EEP_16K : EEP_NONE;
		c.cpak_en     = st[ST_CPAK];
		for (int p = 0; p < 4; p++)
			c.pad_type[p] = pad_type_t'(st[ST_PAD_LO + 2*p +: 2]);
		c.crop_bottom = st[ST_CROP_LO +: 2];
		return c;
	endfunction

	// ====================
	// Monitors
	// ====================
	always @(negedge clk_1x) begin
		if (!arst_n) begin
			pif_cnt = 0;
			ram_cnt = 0;
		end else begin
			if (pif_wr) begin
				if (pif_q.size() == 0) begin
					report_failure("Boot-ROM write seen while none was expected");
				end else begin
					check_pif(pif_q.pop_front(), pif_req);
					pif_cnt++;
				end
			end
			if (ram_wr) begin
				// Stream is held from the write strobe on
				check_bit("ioctl_wait", 1'b1, ioctl_wait);
				if (ram_q.size() == 0) begin
					report_failure("Cartridge RAM write seen while none was expected");
				end else begin
					check_ram(ram_q.pop_front(), ram_req);
					ram_cnt++;
				end
			end
		end
	end

	always @(posedge clk_1x) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			report_failure("Timeout: the tests did not finish within the cycle limit");
	end

	// RAM answers each write 1 to 6 cycles later
	initial begin : ram_responder
		logic [31:0] rnd;
		int          delay;
		ram_ready = 1'b0;
		forever begin
			@(posedge clk_1x);
			#1;
			if (ram_wr) begin
				rnd   = $random(seed);
				delay = 1 + int'(rnd[2:0]) % 6;
				repeat (delay) @(posedge clk_1x);
				#1;
				// Still stalled until the answer arrives
				check_bit("ioctl_wait", 1'b1, ioctl_wait);
				ram_ready = 1'b1;
				@(posedge clk_1x);
				#1;
				ram_ready = 1'b0;
				check_bit("ioctl_wait", 1'b0, ioctl_wait);
			end
		end
	end

	// ====================
	// Stimulus
	// ====================
	task automatic next_slot();
		@(posedge clk_1x);
		#1;
	endtask

	task automatic send_word(input ioctl_addr_t addr, input ioctl_word_t data);
		next_slot();
		while (ioctl_wait)
			next_slot();
		ioctl.wr   = 1'b1;
		ioctl.addr = addr;
		ioctl.data = data;
		next_slot();
		ioctl.wr = 1'b0;
	endtask

	task automatic send_pair(input ioctl_addr_t addr, input ioctl_word_t w0, input ioctl_word_t w1);
		send_word(addr, w0);
		send_word(addr + 27'd2, w1);
	endtask

	task automatic start_download(input ioctl_index_t idx);
		next_slot();
		ioctl.download = 1'b1;
		ioctl.index    = idx;
	endtask

	task automatic stop_download();
		next_slot();
		ioctl.download = 1'b0;
	endtask

	task automatic mount_image(input logic readonly, input logic [31:0] size);
		next_slot();
		img_mounted  = 1'b1;
		img_readonly = readonly;
		img_size     = size;
		next_slot();
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		@(negedge clk_1x);
	endtask

	initial begin : stimulus
		logic [31:0]  rnd;
		ioctl_addr_t  addr;
		ioctl_index_t idx;
		ioctl        = '0;
		status       = '0;
		osd_status   = 1'b0;
		buttons      = 2'b00;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		wait (arst_n === 1'b1);

		// Configuration decode, save type walks all values
		for (int i = 0; i < CFG_VECTORS; i++) begin
			next_slot();
			for (int k = 0; k < 4; k++)
				status[32*k +: 32] = $random(seed);
			status[ST_SAVETYPE_LO +: 3] = 3'(i % 6);
			@(negedge clk_1x);
			check_cfg(decode_status(status), sys_cfg);
			check_bit("core_reset", status[ST_RESET], core_reset);
		end
		next_slot();
		status  = '0;
		buttons = 2'b10;
		@(negedge clk_1x);
		check_bit("core_reset", 1'b1, core_reset);
		next_slot();
		buttons = 2'b01;
		@(negedge clk_1x);
		check_bit("core_reset", 1'b0, core_reset);

		// Autosave on the OSD edge, then with autosave off
		next_slot();
		buttons    = 2'b00;
		osd_status = 1'b1;
		@(negedge clk_1x);
		check_bit("bk_save", 1'b1, bk_save);
		@(negedge clk_1x);
		check_bit("bk_save", 1'b0, bk_save);
		next_slot();
		osd_status              = 1'b0;
		status[ST_AUTOSAVE_OFF] = 1'b1;
		next_slot();
		osd_status = 1'b1;
		@(negedge clk_1x);
		check_bit("bk_save", 1'b0, bk_save);
		next_slot();
		osd_status         = 1'b0;
		status             = '0;
		status[ST_BK_LOAD] = 1'b1;
		status[ST_BK_SAVE] = 1'b1;
		@(negedge clk_1x);
		check_bit("bk_load", 1'b1, bk_load);
		check_bit("bk_save", 1'b1, bk_save);
		next_slot();
		status = '0;

		// Mounted image tracking
		mount_image(1'b1, 32'h0000_4000);
		check_bit("use_img", 1'b0, use_img);
		mount_image(1'b0, 32'h0000_0000);
		check_bit("use_img", 1'b0, use_img);
		mount_image(1'b0, 32'h0000_4000);
		check_bit("use_img", 1'b1, use_img);

		// Boot ROM, lower then upper half
		for (int half = 0; half < 2; half++) begin
			idx = ioctl_index_t'(64 * half);
			start_download(idx);
			for (int i = 0; i < PIF_PAIRS; i++) begin
				rnd  = $random(seed);
				addr = ioctl_addr_t'(4 * i);
				pif_q.push_back(swap_pif_pair(idx, addr, rnd[15:0], rnd[31:16]));
				send_pair(addr, rnd[15:0], rnd[31:16]);
			end
			stop_download();
		end
		repeat (3) next_slot();
		check_count("pif_wr count", 2 * PIF_PAIRS, pif_cnt);

		// Cartridge download with random RAM latency
		start_download(8'd1);
		next_slot();
		@(negedge clk_1x);
		check_bit("core_reset", 1'b1, core_reset);
		check_bit("bk_load", 1'b0, bk_load);
		@(negedge clk_1x);
		check_bit("use_img", 1'b0, use_img);
		next_slot();
		img_mounted  = 1'b1;
		img_readonly = 1'b1;
		@(negedge clk_1x);
		check_bit("bk_load", 1'b1, bk_load);
		next_slot();
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		for (int i = 0; i < CART_PAIRS; i++) begin
			rnd  = $random(seed);
			addr = ioctl_addr_t'(4 * i);
			ram_q.push_back(pack_cart_pair(addr, rnd[15:0], rnd[31:16]));
			send_pair(addr, rnd[15:0], rnd[31:16]);
		end
		while (ioctl_wait)
			next_slot();
		stop_download();
		repeat (3) next_slot();
		@(negedge clk_1x);
		check_count("ram_wr count", CART_PAIRS, ram_cnt);
		check_bit("cart_loaded", 1'b1, cart_loaded);
		check_bit("core_reset", 1'b0, core_reset);

		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: test/n64_host_checker.sv
// Host bridge protocol checks
// Concurrent assertions on the RAM and boot-ROM write strobes
`timescale 1ns/1ps

module n64_host_checker (
	input logic clk_1x,
	input logic arst_n,
	input logic ram_wr,
	input logic pif_wr,
	input logic ioctl_wait,
	input logic cart_download
);

	// RAM writes only come out of a cartridge download
	a_wr_in_download: assert property (
		@(posedge clk_1x) disable iff (!arst_n) ram_wr |-> cart_download
	) else $error("ram_wr outside cartridge download");

	a_one_write_port: assert property (
		@(posedge clk_1x) disable iff (!arst_n) !(ram_wr && pif_wr)
	) else $error("ram_wr and pif_wr high in the same cycle");

	// Source must never stay stalled once the download is gone
	a_wait_release: assert property (
		@(posedge clk_1x) disable iff (!arst_n) $fell(cart_download) |=> !ioctl_wait
	) else $error("ioctl_wait still high after cartridge download ended");

	a_single_outstanding: assert property (
		@(posedge clk_1x) disable iff (!arst_n) (ioctl_wait && $past(ioctl_wait)) |-> !ram_wr
	) else $error("second ram_wr while the first is outstanding");

endmodule

bind n64_host_bridge n64_host_checker u_checker (
	.clk_1x        (clk_1x),
	.arst_n        (arst_n),
	.ram_wr        (ram_wr),
	.pif_wr        (pif_wr),
	.ioctl_wait    (ioctl_wait),
	.cart_download (cart_download)
);

// File: test/tb_clock.sv
// Testbench clock and reset
// 20 ns clock, reset held low for the first 8 cycles
`timescale 1ns/1ps

module tb_clock (
	output logic clk_1x,
	output logic arst_n
);

	initial begin
		clk_1x = 1'b0;
		forever #10 clk_1x = ~clk_1x;
	end

	// Release just after an edge, away from the flops
	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk_1x);
		#1;
		arst_n = 1'b1;
	end

endmodule

// File: hdl/n64_host_bridge.sv
// Host bridge top level
// Download stream to boot-ROM and cartridge RAM writes, backup
// triggers, configuration decode and core reset
`timescale 1ns/1ps

module n64_host_bridge import n64_host_pkg::*; (
	input  logic         clk_1x,
	input  logic         arst_n,
	// Download stream
	input  ioctl_bus_t   ioctl,
	output logic         ioctl_wait,
	// Boot ROM
	output logic         pif_wr,
	output pif_wr_t      pif_req,
	// Cartridge RAM
	output logic         ram_wr,
	output ram_req_t     ram_req,
	input  logic         ram_ready,
	output logic         cart_loaded,
	// Menu and backup image
	input  host_status_t status,
	input  logic         osd_status,
	input  logic [1:0]   buttons,
	input  logic         img_mounted,
	input  logic         img_readonly,
	input  logic [31:0]  img_size,
	output logic         bk_load,
	output logic         bk_save,
	output logic         use_img,
	// Core side
	output sys_cfg_t     sys_cfg,
	output logic         core_reset
);

	logic cart_download;

	pifrom_loader u_pifrom_loader (
		.clk_1x  (clk_1x),
		.arst_n  (arst_n),
		.ioctl   (ioctl),
		.pif_wr  (pif_wr),
		.pif_req (pif_req)
	);

	cart_loader u_cart_loader (
		.clk_1x        (clk_1x),
		.arst_n        (arst_n),
		.ioctl         (ioctl),
		.ram_ready     (ram_ready),
		.ram_wr        (ram_wr),
		.ram_req       (ram_req),
		.ioctl_wait    (ioctl_wait),
		.cart_download (cart_download),
		.cart_loaded   (cart_loaded)
	);

	backup_ctrl u_backup_ctrl (
		.clk_1x        (clk_1x),
		.arst_n        (arst_n),
		.status        (status),
		.osd_status    (osd_status),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.use_img       (use_img)
	);

	config_decode u_config_decode (
		.status        (status),
		.buttons       (buttons),
		.cart_download (cart_download),
		.sys_cfg       (sys_cfg),
		.core_reset    (core_reset)
	);

endmodule

// File: hdl/config_decode.sv
// System configuration decoder
// Pulls the console settings out of the menu status vector
// and forms the core reset
`timescale 1ns/1ps

module config_decode import n64_host_pkg::*; (
	input  host_status_t status,
	input  logic [1:0]   buttons,
	input  logic         cart_download,
	output sys_cfg_t     sys_cfg,
	output logic         core_reset
);

	// User button, menu reset, or a cart being loaded
	assign core_reset = buttons[1] | status[ST_RESET] | cart_download;

	always_comb begin
		sys_cfg             = '0;
		sys_cfg.pal         = status[ST_PAL];
		// Menu bit selects 4 MB, default is 8 MB
		sys_cfg.ram8mb      = ~status[ST_RAM4MB];
		sys_cfg.cic_type    = status[ST_CIC_LO +: 4];
		sys_cfg.save_type   = save_type_t'(status[ST_SAVETYPE_LO +: 3]);
		sys_cfg.cpak_en     = status[ST_CPAK];
		sys_cfg.crop_bottom = status[ST_CROP_LO +: 2];

		for (int i = 0; i < 4; i++) begin
			sys_cfg.pad_type[i] = pad_type_t'(status[ST_PAD_LO + 2*i +: 2]);
		end

		// EEPROM size only for the EEPROM save types
		case (sys_cfg.save_type)
			SAVE_EEPROM4:  sys_cfg.eeprom_type = EEP_4K;
			SAVE_EEPROM16: sys_cfg.eeprom_type = EEP_16K;
			default:       sys_cfg.eeprom_type = EEP_NONE;
		endcase
	end

endmodule

// File: hdl/backup_ctrl.sv
// Backup memory control
// Load and save triggers for the save image, autosave when
// the menu closes, and tracking of a usable mounted image
`timescale 1ns/1ps

module backup_ctrl import n64_host_pkg::*; (
	input  logic         clk_1x,
	input  logic         arst_n,
	input  host_status_t status,
	input  logic         osd_status,
	input  logic         cart_download,
	input  logic         img_mounted,
	input  logic         img_readonly,
	input  logic [31:0]  img_size,
	output logic         bk_load,
	output logic         bk_save,
	output logic         use_img
);

	logic osd_status_q;
	logic cart_download_q;

	// Reload the save whenever a cart arrives with an image mounted
	assign bk_load = status[ST_BK_LOAD] | (cart_download & img_mounted);

	// Menu save, or autosave on the OSD edge
	assign bk_save = status[ST_BK_SAVE]
		| (osd_status & ~osd_status_q & ~status[ST_AUTOSAVE_OFF]);

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			osd_status_q    <= 1'b0;
			cart_download_q <= 1'b0;
			use_img         <= 1'b0;
		end else begin
			osd_status_q    <= osd_status;
			cart_download_q <= cart_download;

			if (cart_download && !cart_download_q) begin
				use_img <= 1'b0;
			end
			// A fresh writable mount wins over the clear
			if (img_mounted && (img_size != '0) && !img_readonly) begin
				use_img <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/cart_loader.sv
// Cartridge loader
// Packs download word pairs into 32-bit RAM writes at the
// cartridge base and stalls the stream until the RAM answers
`timescale 1ns/1ps

module cart_loader import n64_host_pkg::*; (
	input  logic       clk_1x,
	input  logic       arst_n,
	input  ioctl_bus_t ioctl,
	input  logic       ram_ready,
	output logic       ram_wr,
	output ram_req_t   ram_req,
	output logic       ioctl_wait,
	output logic       cart_download,
	output logic       cart_loaded
);

	logic cart_sel;

	assign cart_sel = ioctl.download && (ioctl.index[5:0] == IDX_CART);

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			cart_download <= 1'b0;
			cart_loaded   <= 1'b0;
			ram_wr        <= 1'b0;
			ram_req       <= '0;
			ioctl_wait    <= 1'b0;
		end else begin
			cart_download <= cart_sel;
			ram_wr        <= 1'b0;

			if (cart_download) begin
				// Sticky until reset
				cart_loaded <= 1'b1;

				if (ioctl.wr) begin
					if (!ioctl.addr[1]) begin
						// Low half first, address taken here
						ram_req.data[15:0] <= ioctl.data;
						ram_req.addr       <= ioctl.addr + CART_BASE_ADDR;
					end else begin
						ram_req.data[31:16] <= ioctl.data;
						ram_wr              <= 1'b1;
						ioctl_wait          <= 1'b1;
					end
				end

				// Write accepted, release the stream
				if (ram_ready) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				// Download ended, never leave the source stuck
				ioctl_wait <= 1'b0;
			end
		end
	end

endmodule

// File: hdl/pifrom_loader.sv
// Boot-ROM loader
// Collects two download words into one byte-swapped 32-bit
// PIF ROM word and strobes it out
`timescale 1ns/1ps

module pifrom_loader import n64_host_pkg::*; (
	input  logic       clk_1x,
	input  logic       arst_n,
	input  ioctl_bus_t ioctl,
	output logic       pif_wr,
	output pif_wr_t    pif_req
);

	// Registered target flag, one cycle behind the stream
	logic pif_download;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			pif_download <= 1'b0;
			pif_wr       <= 1'b0;
			pif_req      <= '0;
		end else begin
			pif_download <= ioctl.download && (ioctl.index[5:0] == IDX_PIFROM);
			pif_wr       <= 1'b0;

			if (pif_download && ioctl.wr) begin
				if (!ioctl.addr[1]) begin
					// Upper half, bytes swapped
					pif_req.data[31:24] <= ioctl.data[7:0];
					pif_req.data[23:16] <= ioctl.data[15:8];
					// Index bit 6 selects the upper ROM half
					pif_req.addr        <= {ioctl.index[6], ioctl.addr[10:2]};
				end else begin
					pif_req.data[15:8]  <= ioctl.data[7:0];
					pif_req.data[7:0]   <= ioctl.data[15:8];
					pif_wr              <= 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/n64_host_pkg.sv
// Host bridge shared definitions
// Download stream, RAM and boot-ROM write types, menu status
// bit positions and the decoded system configuration
package n64_host_pkg;

	// ====================
	// Widths with meaning
	// ====================
	typedef logic [15:0]  ioctl_word_t;
	typedef logic [26:0]  ioctl_addr_t;
	typedef logic [7:0]   ioctl_index_t;
	typedef logic [26:0]  ram_addr_t;
	typedef logic [31:0]  data32_t;
	typedef logic [9:0]   pif_addr_t;
	typedef logic [127:0] host_status_t;

	typedef enum logic [2:0] {
		SAVE_NONE,
		SAVE_EEPROM4,
		SAVE_EEPROM16,
		SAVE_SRAM32,
		SAVE_SRAM96,
		SAVE_FLASH
	} save_type_t;

	typedef enum logic [1:0] {
		EEP_NONE,
		EEP_4K,
		EEP_16K
	} eeprom_type_t;

	typedef enum logic [1:0] {
		PAD_NONE,
		PAD_CPAK,
		PAD_RUMBLE
	} pad_type_t;

	// ====================
	// Bundles
	// ====================
	typedef struct packed {
		logic         download;
		logic         wr;
		ioctl_index_t index;
		ioctl_addr_t  addr;
		ioctl_word_t  data;
	} ioctl_bus_t;

	typedef struct packed {
		ram_addr_t addr;
		data32_t   data;
	} ram_req_t;

	typedef struct packed {
		pif_addr_t addr;
		data32_t   data;
	} pif_wr_t;

	typedef struct packed {
		logic               pal;
		logic               ram8mb;
		logic [3:0]         cic_type;
		save_type_t         save_type;
		eeprom_type_t       eeprom_type;
		logic               cpak_en;
		pad_type_t [3:0]    pad_type;
		logic [1:0]         crop_bottom;
	} sys_cfg_t;

	// Download targets, matched on index[5:0]
	localparam logic [5:0] IDX_PIFROM = 6'd0;
	localparam logic [5:0] IDX_CART   = 6'd1;

	// Cartridge image sits 8 MB into the RAM
	localparam ram_addr_t CART_BASE_ADDR = 27'd8388608;

	// ====================
	// Status bit map
	// ====================
	localparam int ST_RESET        = 0;
	localparam int ST_BK_LOAD      = 40;
	localparam int ST_BK_SAVE      = 41;
	localparam int ST_AUTOSAVE_OFF = 42;
	localparam int ST_CROP_LO      = 44;
	localparam int ST_PAD_LO       = 50;
	localparam int ST_CIC_LO       = 65;
	localparam int ST_RAM4MB       = 70;
	localparam int ST_CPAK         = 71;
	localparam int ST_SAVETYPE_LO  = 75;
	localparam int ST_PAL          = 79;

endpackage
